// File: hdl/vmem_pkg.sv
package vmem_pkg;

	// client address word and bank RAM widths
	localparam int ADDR_W = 16;
	localparam int DATA_W = 16;
	localparam int OFFS_W = 14;

	// one RAM per value of the bank select bits
	localparam int N_BANKS = 4;

	// per-bank grant state, one state per client in priority order
	typedef enum logic [2:0] {
		idle      = 3'd0,
		grant_sp  = 3'd1,
		grant_bg0 = 3'd2,
		grant_bg1 = 3'd3,
		grant_fl  = 3'd4,
		grant_cpu = 3'd5
	} grant_state_e;

	// client address, whole word or bank select plus word offset
	typedef union packed {
		logic [ADDR_W-1:0] word;
		struct packed {
			logic [ADDR_W-OFFS_W-1:0] bank;
			logic [OFFS_W-1:0]        offs;
		} fld;
	} vmem_addr_u;

endpackage

// File: hdl/bank_ram.sv
`timescale 1ns/1ps

module bank_ram (
	input  logic                        CLK,
	input  logic [vmem_pkg::OFFS_W-1:0] addr,
	input  logic [vmem_pkg::DATA_W-1:0] din,
	input  logic                        wr,
	output logic [vmem_pkg::DATA_W-1:0] dout
);
	import vmem_pkg::*;

	// 16K words per bank
	logic [DATA_W-1:0] mem [2**OFFS_W];

	always_ff @(posedge CLK) begin
		if (wr) begin
			mem[addr] <= din;
		end
	end

	// registered read, old contents on a same-cycle write
	always_ff @(posedge CLK) begin
		dout <= mem[addr];
	end

endmodule

// File: hdl/bank_arbiter.sv
`timescale 1ns/1ps

module bank_arbiter #(
	parameter logic [1:0] BANK_ID = 2'd0
) (
	input  logic                        CLK,
	input  logic                        RSTb,
	input  vmem_pkg::vmem_addr_u        sprite_addr,
	input  logic                        sprite_rvalid,
	input  vmem_pkg::vmem_addr_u        bg0_addr,
	input  logic                        bg0_rvalid,
	input  vmem_pkg::vmem_addr_u        bg1_addr,
	input  logic                        bg1_rvalid,
	input  vmem_pkg::vmem_addr_u        fl_addr,
	input  logic [vmem_pkg::DATA_W-1:0] fl_data,
	input  logic                        fl_wvalid,
	input  vmem_pkg::vmem_addr_u        cpu_addr,
	input  logic [vmem_pkg::DATA_W-1:0] cpu_data_in,
	input  logic                        cpu_valid,
	input  logic                        cpu_wr,
	input  logic [vmem_pkg::DATA_W-1:0] mem_dout,
	output logic [vmem_pkg::OFFS_W-1:0] mem_addr,
	output logic [vmem_pkg::DATA_W-1:0] mem_din,
	output logic                        mem_wr,
	output logic                        sprite_rready,
	output logic [vmem_pkg::DATA_W-1:0] sprite_data,
	output logic                        bg0_rready,
	output logic [vmem_pkg::DATA_W-1:0] bg0_data,
	output logic                        bg1_rready,
	output logic [vmem_pkg::DATA_W-1:0] bg1_data,
	output logic                        fl_wready,
	output logic                        cpu_ready,
	output logic [vmem_pkg::DATA_W-1:0] cpu_data
);
	import vmem_pkg::*;

	grant_state_e state;
	grant_state_e state_next;
	grant_state_e pick;
	grant_state_e sel;

	// highest-priority request aimed at this bank
	always_comb begin
		if (sprite_rvalid && sprite_addr.fld.bank == BANK_ID)
			pick = grant_sp;
		else if (bg0_rvalid && bg0_addr.fld.bank == BANK_ID)
			pick = grant_bg0;
		else if (bg1_rvalid && bg1_addr.fld.bank == BANK_ID)
			pick = grant_bg1;
		else if (fl_wvalid && fl_addr.fld.bank == BANK_ID)
			pick = grant_fl;
		else if (cpu_valid && cpu_addr.fld.bank == BANK_ID)
			pick = grant_cpu;
		else
			pick = idle;
	end

	// grant held until the owner drops valid, then one release cycle
	always_comb begin
		state_next = state;
		case (state)
			idle:      state_next = pick;
			grant_sp:  state_next = sprite_rvalid ? grant_sp : idle;
			grant_bg0: state_next = bg0_rvalid ? grant_bg0 : idle;
			grant_bg1: state_next = bg1_rvalid ? grant_bg1 : idle;
			grant_fl:  state_next = fl_wvalid ? grant_fl : idle;
			grant_cpu: state_next = cpu_valid ? grant_cpu : idle;
			default:   state_next = idle;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (!RSTb)
			state <= idle;
		else
			state <= state_next;
	end

	// RAM port follows the winner in the decision cycle, then the owner
	assign sel = (state == idle) ? pick : state;

	always_comb begin
		mem_addr = '0;
		mem_din  = '0;
		mem_wr   = 1'b0;
		case (sel)
			grant_sp:  mem_addr = sprite_addr.fld.offs;
			grant_bg0: mem_addr = bg0_addr.fld.offs;
			grant_bg1: mem_addr = bg1_addr.fld.offs;
			grant_fl: begin
				mem_addr = fl_addr.fld.offs;
				mem_din  = fl_data;
				mem_wr   = fl_wvalid;
			end
			grant_cpu: begin
				mem_addr = cpu_addr.fld.offs;
				mem_din  = cpu_data_in;
				mem_wr   = cpu_valid & cpu_wr;
			end
			default: ;
		endcase
	end

	// returns to the clients, data forced to zero outside a grant
	assign sprite_rready = (state == grant_sp);
	assign bg0_rready    = (state == grant_bg0);
	assign bg1_rready    = (state == grant_bg1);
	assign fl_wready     = (state == grant_fl);
	assign cpu_ready     = (state == grant_cpu);

	assign sprite_data = sprite_rready ? mem_dout : '0;
	assign bg0_data    = bg0_rready ? mem_dout : '0;
	assign bg1_data    = bg1_rready ? mem_dout : '0;
	assign cpu_data    = cpu_ready ? mem_dout : '0;

endmodule

// File: hdl/memory_arbiter.sv
`timescale 1ns/1ps

module memory_arbiter #(
	parameter int N_BANKS = vmem_pkg::N_BANKS
) (
	input  logic                        CLK,
	input  logic                        RSTb,
	input  logic [vmem_pkg::ADDR_W-1:0] sprite_addr,
	output logic [vmem_pkg::DATA_W-1:0] sprite_data,
	input  logic                        sprite_rvalid,
	output logic                        sprite_rready,
	input  logic [vmem_pkg::ADDR_W-1:0] bg0_addr,
	output logic [vmem_pkg::DATA_W-1:0] bg0_data,
	input  logic                        bg0_rvalid,
	output logic                        bg0_rready,
	input  logic [vmem_pkg::ADDR_W-1:0] bg1_addr,
	output logic [vmem_pkg::DATA_W-1:0] bg1_data,
	input  logic                        bg1_rvalid,
	output logic                        bg1_rready,
	input  logic [vmem_pkg::ADDR_W-1:0] fl_addr,
	input  logic [vmem_pkg::DATA_W-1:0] fl_data,
	input  logic                        fl_wvalid,
	output logic                        fl_wready,
	input  logic [vmem_pkg::ADDR_W-1:0] cpu_addr,
	input  logic [vmem_pkg::DATA_W-1:0] cpu_data_in,
	output logic [vmem_pkg::DATA_W-1:0] cpu_data,
	input  logic                        cpu_valid,
	input  logic                        cpu_wr,
	output logic                        cpu_ready,
	output logic [vmem_pkg::OFFS_W-1:0] bank_addr [N_BANKS],
	output logic [vmem_pkg::DATA_W-1:0] bank_din [N_BANKS],
	output logic [N_BANKS-1:0]          bank_wr,
	input  logic [vmem_pkg::DATA_W-1:0] bank_dout [N_BANKS]
);
	import vmem_pkg::*;

	vmem_addr_u sp_a;
	vmem_addr_u bg0_a;
	vmem_addr_u bg1_a;
	vmem_addr_u fl_a;
	vmem_addr_u cpu_a;

	// per-bank returns, at most one bank active per client
	logic [N_BANKS-1:0] sp_rdy;
	logic [N_BANKS-1:0] bg0_rdy;
	logic [N_BANKS-1:0] bg1_rdy;
	logic [N_BANKS-1:0] fl_rdy;
	logic [N_BANKS-1:0] cpu_rdy;
	logic [DATA_W-1:0]  sp_d [N_BANKS];
	logic [DATA_W-1:0]  bg0_d [N_BANKS];
	logic [DATA_W-1:0]  bg1_d [N_BANKS];
	logic [DATA_W-1:0]  cpu_d [N_BANKS];

	assign sp_a.word  = sprite_addr;
	assign bg0_a.word = bg0_addr;
	assign bg1_a.word = bg1_addr;
	assign fl_a.word  = fl_addr;
	assign cpu_a.word = cpu_addr;

	for (genvar b = 0; b < N_BANKS; b++) begin : g_bank
		bank_arbiter #(
			.BANK_ID(2'(b))
		) u_arb (
			.CLK(CLK), .RSTb(RSTb),
			.sprite_addr(sp_a), .sprite_rvalid(sprite_rvalid),
			.bg0_addr(bg0_a), .bg0_rvalid(bg0_rvalid),
			.bg1_addr(bg1_a), .bg1_rvalid(bg1_rvalid),
			.fl_addr(fl_a), .fl_data(fl_data), .fl_wvalid(fl_wvalid),
			.cpu_addr(cpu_a), .cpu_data_in(cpu_data_in),
			.cpu_valid(cpu_valid), .cpu_wr(cpu_wr),
			.mem_dout(bank_dout[b]), .mem_addr(bank_addr[b]),
			.mem_din(bank_din[b]), .mem_wr(bank_wr[b]),
			.sprite_rready(sp_rdy[b]), .sprite_data(sp_d[b]),
			.bg0_rready(bg0_rdy[b]), .bg0_data(bg0_d[b]),
			.bg1_rready(bg1_rdy[b]), .bg1_data(bg1_d[b]),
			.fl_wready(fl_rdy[b]),
			.cpu_ready(cpu_rdy[b]), .cpu_data(cpu_d[b])
		);
	end

	assign sprite_rready = |sp_rdy;
	assign bg0_rready    = |bg0_rdy;
	assign bg1_rready    = |bg1_rdy;
	assign fl_wready     = |fl_rdy;
	assign cpu_ready     = |cpu_rdy;

	// idle banks return zero, so a plain OR merges the data
	always_comb begin
		sprite_data = '0;
		bg0_data    = '0;
		bg1_data    = '0;
		cpu_data    = '0;
		for (int b = 0; b < N_BANKS; b++) begin
			sprite_data |= sp_d[b];
			bg0_data    |= bg0_d[b];
			bg1_data    |= bg1_d[b];
			cpu_data    |= cpu_d[b];
		end
	end

endmodule

// File: hdl/video_memory.sv
`timescale 1ns/1ps

module video_memory #(
	parameter int N_BANKS = vmem_pkg::N_BANKS
) (
	input  logic                        CLK,
	input  logic                        RSTb,
	input  logic [vmem_pkg::ADDR_W-1:0] sprite_addr,
	output logic [vmem_pkg::DATA_W-1:0] sprite_data,
	input  logic                        sprite_rvalid,
	output logic                        sprite_rready,
	input  logic [vmem_pkg::ADDR_W-1:0] bg0_addr,
	output logic [vmem_pkg::DATA_W-1:0] bg0_data,
	input  logic                        bg0_rvalid,
	output logic                        bg0_rready,
	input  logic [vmem_pkg::ADDR_W-1:0] bg1_addr,
	output logic [vmem_pkg::DATA_W-1:0] bg1_data,
	input  logic                        bg1_rvalid,
	output logic                        bg1_rready,
	input  logic [vmem_pkg::ADDR_W-1:0] fl_addr,
	input  logic [vmem_pkg::DATA_W-1:0] fl_data,
	input  logic                        fl_wvalid,
	output logic                        fl_wready,
	input  logic [vmem_pkg::ADDR_W-1:0] cpu_addr,
	input  logic [vmem_pkg::DATA_W-1:0] cpu_data_in,
	output logic [vmem_pkg::DATA_W-1:0] cpu_data,
	input  logic                        cpu_valid,
	input  logic                        cpu_wr,
	output logic                        cpu_ready
);
	import vmem_pkg::*;

	// arbiter to RAM, one port per bank
	logic [OFFS_W-1:0]  bank_addr [N_BANKS];
	logic [DATA_W-1:0]  bank_din [N_BANKS];
	logic [N_BANKS-1:0] bank_wr;
	logic [DATA_W-1:0]  bank_dout [N_BANKS];

	memory_arbiter #(
		.N_BANKS(N_BANKS)
	) u_arbiter (
		.CLK(CLK), .RSTb(RSTb),
		.sprite_addr(sprite_addr), .sprite_data(sprite_data),
		.sprite_rvalid(sprite_rvalid), .sprite_rready(sprite_rready),
		.bg0_addr(bg0_addr), .bg0_data(bg0_data),
		.bg0_rvalid(bg0_rvalid), .bg0_rready(bg0_rready),
		.bg1_addr(bg1_addr), .bg1_data(bg1_data),
		.bg1_rvalid(bg1_rvalid), .bg1_rready(bg1_rready),
		.fl_addr(fl_addr), .fl_data(fl_data),
		.fl_wvalid(fl_wvalid), .fl_wready(fl_wready),
		.cpu_addr(cpu_addr), .cpu_data_in(cpu_data_in), .cpu_data(cpu_data),
		.cpu_valid(cpu_valid), .cpu_wr(cpu_wr), .cpu_ready(cpu_ready),
		.bank_addr(bank_addr), .bank_din(bank_din),
		.bank_wr(bank_wr), .bank_dout(bank_dout)
	);

	for (genvar b = 0; b < N_BANKS; b++) begin : g_ram
		bank_ram u_ram (
			.CLK(CLK),
			.addr(bank_addr[b]),
			.din(bank_din[b]),
			.wr(bank_wr[b]),
			.dout(bank_dout[b])
		);
	end

endmodule

// File: dv/vmem_checker.sv
`timescale 1ns/1ps

module vmem_checker (
	input logic                        CLK,
	input logic                        RSTb,
	input logic [4:0]                  valid,
	input logic [4:0]                  ready,
	input logic [vmem_pkg::DATA_W-1:0] sp_d,
	input logic [vmem_pkg::DATA_W-1:0] bg0_d,
	input logic [vmem_pkg::DATA_W-1:0] bg1_d,
	input logic [vmem_pkg::DATA_W-1:0] cpu_d
);
	int fail_rise = 0;
	int fail_hold = 0;
	int fail_zero = 0;

	// ready answers only a request seen the cycle before
	a_rise: assert property (@(posedge CLK) disable iff (!RSTb)
		(ready & ~$past(ready) & ~$past(valid)) == 5'b0)
	else begin
		$error("ready rose without a request in the previous cycle");
		fail_rise++;
	end

	a_hold: assert property (@(posedge CLK) disable iff (!RSTb)
		($past(valid & ready) & ~ready) == 5'b0)
	else begin
		$error("ready dropped while valid was still high");
		fail_hold++;
	end

	// read data zero outside a grant
	a_zero: assert property (@(posedge CLK) disable iff (!RSTb)
		(ready[0] || sp_d == '0) && (ready[1] || bg0_d == '0) &&
		(ready[2] || bg1_d == '0) && (ready[4] || cpu_d == '0))
	else begin
		$error("read data nonzero while ready was low");
		fail_zero++;
	end

endmodule

bind memory_arbiter vmem_checker u_chk (
	.CLK(CLK), .RSTb(RSTb),
	.valid({cpu_valid, fl_wvalid, bg1_rvalid, bg0_rvalid, sprite_rvalid}),
	.ready({cpu_ready, fl_wready, bg1_rready, bg0_rready, sprite_rready}),
	.sp_d(sprite_data), .bg0_d(bg0_data), .bg1_d(bg1_data), .cpu_d(cpu_data)
);

// File: dv/tb_video_memory.sv
`timescale 1ns/1ps

module tb_video_memory;

	localparam int N_FL = 16;
	localparam int N_RD = 16;
	localparam int N_CPU = 8;
	localparam int N_CONT = 6;
	// four exchanges per cpu round, five per contention round
	localparam int N_TXN = N_FL + N_RD + 4 * N_CPU + 5 * N_CONT;
	localparam int LIMIT = 40 * N_TXN;

	logic CLK = 1'b0;
	logic RSTb = 1'b0;
	// client index 0 sprite, 1 bg0, 2 bg1, 3 flash, 4 cpu
	logic [15:0] addr [5] = '{default: '0};
	logic [15:0] wdata [5] = '{default: '0};
	logic [4:0]  valid = '0;
	logic        cpu_wr = 1'b0;
	logic [4:0]  ready;
	logic [15:0] rdata [5];
	string       names [5] = '{"sprite", "bg0", "bg1", "fl", "cpu"};

	logic [15:0] mem_model [65536];
	logic [15:0] written [$];
	logic [31:0] lfsr = 32'h2bec7941;
	int          cycles = 0;
	int          lat [5];
	int          t_rdy [5];

	always #2 CLK = ~CLK;

	always @(posedge CLK) begin
		cycles <= cycles + 1;
	end

	always @(posedge CLK) begin
		if (cycles >= LIMIT) begin
			$display("timeout, a handshake did not complete within %0d cycles", LIMIT);
			$display("Finished with errors");
			$fatal(1, "run stopped by the cycle limit");
		end
	end

	video_memory #(.N_BANKS(4)) dut (
		.CLK(CLK), .RSTb(RSTb),
		.sprite_addr(addr[0]), .sprite_data(rdata[0]),
		.sprite_rvalid(valid[0]), .sprite_rready(ready[0]),
		.bg0_addr(addr[1]), .bg0_data(rdata[1]), .bg0_rvalid(valid[1]), .bg0_rready(ready[1]),
		.bg1_addr(addr[2]), .bg1_data(rdata[2]), .bg1_rvalid(valid[2]), .bg1_rready(ready[2]),
		.fl_addr(addr[3]), .fl_data(wdata[3]), .fl_wvalid(valid[3]), .fl_wready(ready[3]),
		.cpu_addr(addr[4]), .cpu_data_in(wdata[4]), .cpu_data(rdata[4]),
		.cpu_valid(valid[4]), .cpu_wr(cpu_wr), .cpu_ready(ready[4])
	);
	assign rdata[3] = '0;

	// galois lfsr, one step per bit taken
	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		end
		return v;
	endfunction

	task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("Error: %s got %h expected %h", what, got, exp);
			$display("Finished with errors");
			$fatal(1, "stopped at the first mismatch");
		end
	endtask

	// one four-phase exchange, latency counted from the cycle valid rises
	task automatic do_access(input int c, input logic [15:0] a, input logic [15:0] d,
			input logic w, output int n_lat, output int t_first);
		int n;
		@(posedge CLK);
		addr[c]  <= a;
		wdata[c] <= d;
		valid[c] <= 1'b1;
		if (c == 4)
			cpu_wr <= w;
		n = 0;
		do begin
			@(negedge CLK);
			n++;
		end while (!ready[c]);
		t_first = cycles;
		n_lat = n - 1;
		if (w) begin
			mem_model[a] = d;
			written.push_back(a);
		end else begin
			check({names[c], "_data"}, 32'(rdata[c]), 32'(mem_model[a]));
		end
		@(posedge CLK);
		valid[c] <= 1'b0;
		// ready held for exactly one cycle past valid
		@(negedge CLK);
		check({names[c], " ready in release cycle"}, 32'(ready[c]), 32'd1);
		@(negedge CLK);
		check({names[c], " ready after release"}, 32'(ready[c]), 32'd0);
	endtask

	initial begin
		logic [15:0] a;
		logic [15:0] b;
		logic [15:0] e;
		logic [15:0] d_fl;
		logic [15:0] d_cpu;
		logic [1:0]  bk;
		logic [1:0]  ob;
		int          c;
		repeat (5) @(posedge CLK);
		RSTb <= 1'b1;
		@(negedge CLK);
		check("ready after reset", 32'(ready), 32'd0);
		// flash has no read data port
		for (int i = 0; i < 5; i++)
			if (i != 3)
				check({names[i], "_data after reset"}, 32'(rdata[i]), 32'd0);

		// flash fills all four banks, display clients read back
		for (int i = 0; i < N_FL; i++) begin
			bk = 2'(i);
			a = {bk, 14'(take_bits(14))};
			do_access(3, a, 16'(take_bits(16)), 1'b1, lat[3], t_rdy[3]);
			check("fl_wready latency", 32'(lat[3]), 32'd1);
			repeat (take_bits(2)) @(posedge CLK);
		end
		for (int i = 0; i < N_RD; i++) begin
			c = take_bits(2) % 3;
			a = written[take_bits(8) % written.size()];
			do_access(c, a, 16'h0, 1'b0, lat[c], t_rdy[c]);
			repeat (take_bits(2)) @(posedge CLK);
		end

		// cpu write and read back, flash busy on another bank alongside
		for (int i = 0; i < N_CPU; i++) begin
			bk = 2'(take_bits(2));
			ob = bk + 2'(1 + take_bits(2) % 3);
			a = {bk, 14'(take_bits(14))};
			b = {ob, 14'(take_bits(14))};
			d_cpu = 16'(take_bits(16));
			d_fl = 16'(take_bits(16));
			fork
				do_access(4, a, d_cpu, 1'b1, lat[4], t_rdy[4]);
				do_access(3, b, d_fl, 1'b1, lat[3], t_rdy[3]);
			join
			check("cpu_ready latency", 32'(lat[4]), 32'd1);
			check("fl_wready latency", 32'(lat[3]), 32'd1);
			repeat (take_bits(2)) @(posedge CLK);
			fork
				do_access(4, a, 16'h0, 1'b0, lat[4], t_rdy[4]);
				do_access(0, b, 16'h0, 1'b0, lat[0], t_rdy[0]);
			join
			check("cpu_ready latency", 32'(lat[4]), 32'd1);
			check("sprite_rready latency", 32'(lat[0]), 32'd1);
		end

		// all five clients hit one idle bank in the same cycle
		for (int i = 0; i < N_CONT; i++) begin
			a = written[take_bits(8) % written.size()];
			b = {a[15:14], 14'(take_bits(14))};
			e = {a[15:14], 14'(take_bits(14))};
			d_fl = 16'(take_bits(16));
			d_cpu = 16'(take_bits(16));
			fork
				do_access(0, a, 16'h0, 1'b0, lat[0], t_rdy[0]);
				do_access(1, a, 16'h0, 1'b0, lat[1], t_rdy[1]);
				do_access(2, a, 16'h0, 1'b0, lat[2], t_rdy[2]);
				do_access(3, b, d_fl, 1'b1, lat[3], t_rdy[3]);
				do_access(4, e, d_cpu, 1'b1, lat[4], t_rdy[4]);
			join
			check("sprite_rready latency", 32'(lat[0]), 32'd1);
			for (int k = 0; k < 4; k++)
				check({names[k + 1], " ready after ", names[k]},
					32'(t_rdy[k] < t_rdy[k + 1]), 32'd1);
			repeat (take_bits(2)) @(posedge CLK);
		end

		repeat (4) @(posedge CLK);
		if (dut.u_arbiter.u_chk.fail_rise + dut.u_arbiter.u_chk.fail_hold
				+ dut.u_arbiter.u_chk.fail_zero == 0) begin
			$display("Finished with no errors");
			$finish;
		end else begin
			$display("handshake assertions failed in the bound checker");
			$display("Finished with errors");
			$fatal(1, "checker assertions failed");
		end
	end

endmodule

// File: tb.f
hdl/vmem_pkg.sv
hdl/bank_ram.sv
hdl/bank_arbiter.sv
hdl/memory_arbiter.sv
hdl/video_memory.sv
dv/vmem_checker.sv
dv/tb_video_memory.sv

// File: run_sim.sh
#!/bin/sh
# build and run the video memory testbench with Verilator
cd "$(dirname "$0")" || exit 1

OBJ=obj_dir
LOG=sim.log

verilator --binary --timing --assert -f tb.f --top-module tb_video_memory \
	-Mdir "$OBJ" -o sim_video_memory
if [ $? -ne 0 ]; then
	echo "build failed"
	exit 1
fi

"$OBJ/sim_video_memory" > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Finished with errors" "$LOG"; then
	echo "simulation FAILED"
	exit 1
fi
if [ $status -ne 0 ]; then
	echo "simulator exited with status $status"
	exit 1
fi
echo "simulation passed"
exit 0
